// File: scan_cfg.svh
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

// source line geometry
`define SCAN_LINE_PIXELS 256    // active pixels per source line
`define SCAN_ADDR_W      8      // line buffer address bits

// horizontal segments of one output line, in clk_vga cycles
`define SCAN_HSYNC_CYC   96     // hsync pulse
`define SCAN_FRONT_CYC   16     // porch after hsync
`define SCAN_LEFT_CYC    64     // blank margin each side of the picture
`define SCAN_BACK_CYC    48     // porch before next hsync

// 96 + 16 + 64 + 512 + 64 + 48 = 800 cycles per output line,
// so one 1600-cycle source line gives exactly two output lines

`endif

// File: scan_video_pkg.sv
package scan_video_pkg;

    // source pixel, 4 bits per channel
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb555_t;                     // output pixel

    // timing outputs towards the monitor
    typedef struct packed {
        logic hsync;                // active low
        logic vsync;                // active low
        logic hb;                   // high in horizontal blank
        logic vb;                   // high in vertical blank
        logic de;                   // picture visible
    } vga_sync_t;

    // blanking levels from the 15 kHz core
    typedef struct packed {
        logic lhbl;                 // low in horizontal blank
        logic lvbl;                 // low in vertical blank
    } src_sync_t;

endpackage

// File: scan_ctrl_pkg.sv
`include "scan_cfg.svh"

package scan_ctrl_pkg;

    // horizontal segments of an output line
    typedef enum logic [1:0] {
        SYNC  = 2'd0,               // hsync low, or waiting for source line end
        FRONT = 2'd1,
        LINE  = 2'd2,               // left margin, picture, right margin
        BACK  = 2'd3
    } timer_state_e;

    // read request from timer to line buffer
    typedef struct packed {
        logic [`SCAN_ADDR_W-1:0] addr;
        logic                    bank;   // bank shown on this line pair
    } lbuf_rd_t;

endpackage

// File: scan_line_buffer.sv
`include "scan_cfg.svh"

module scan_line_buffer import scan_video_pkg::*, scan_ctrl_pkg::*; #(
    parameter type pixel_t = rgb444_t
) (
    input  logic      clk_vga,
    input  logic      rst,
    input  pixel_t    pix,
    input  logic      pix_cen,
    input  src_sync_t src,
    input  lbuf_rd_t  rd,
    output pixel_t    q0,
    output pixel_t    q1,
    output logic      wr_bank,
    output logic      lhbl_fall
);

    pixel_t mem0 [`SCAN_LINE_PIXELS];
    pixel_t mem1 [`SCAN_LINE_PIXELS];

    logic [`SCAN_ADDR_W-1:0] wr_addr;
    logic                    last_lhbl;
    logic                    fall;

    assign fall = last_lhbl & ~src.lhbl;    // end of active source line

    // write pointer and bank selection
    always_ff @(posedge clk_vga or posedge rst) begin
        if (rst) begin
            wr_addr   <= '0;
            wr_bank   <= 1'b0;
            last_lhbl <= 1'b0;
            lhbl_fall <= 1'b0;
        end else begin
            last_lhbl <= src.lhbl;
            lhbl_fall <= fall;              // same edge as the bank flip
            if (fall) begin
                wr_addr <= '0;
                wr_bank <= ~wr_bank;
            end else if (src.lhbl && pix_cen) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // storage, one bank filling while the other is shown
    always_ff @(posedge clk_vga) begin
        if (src.lhbl && pix_cen) begin
            if (wr_bank)
                mem1[wr_addr] <= pix;
            else
                mem0[wr_addr] <= pix;
        end
    end

    // both banks read every cycle, the mixer picks or blends them
    always_ff @(posedge clk_vga) begin
        q0 <= mem0[rd.addr];
        q1 <= mem1[rd.addr];
    end

endmodule

// File: scan_vga_timer.sv
`include "scan_cfg.svh"

module scan_vga_timer import scan_video_pkg::*, scan_ctrl_pkg::*; (
    input  logic      clk_vga,
    input  logic      rst,
    input  src_sync_t src,
    input  logic      lhbl_fall,
    input  logic      wr_bank,
    output lbuf_rd_t  rd,
    output logic      scanline,
    output vga_sync_t sync
);

    localparam logic [`SCAN_ADDR_W:0] POS_LAST = (`SCAN_ADDR_W+1)'(2 * `SCAN_LINE_PIXELS - 1);

    timer_state_e            state;
    logic [6:0]              cnt;
    logic [`SCAN_ADDR_W:0]   pos;       // read address over the doubling bit
    logic                    act;       // picture part of LINE
    logic                    right;     // right margin of LINE
    logic                    wait_fall; // next SYNC ends on source line end
    logic                    rd_bank;
    logic                    hsync_q;
    logic                    vsync_q;
    logic                    vsync_cnt;
    logic                    vsync_req;
    logic                    last_lvbl;
    logic                    vb_q;
    logic [2:0]              de_dly;
    logic [2:0]              hb_dly;

    assign rd.addr = pos[`SCAN_ADDR_W:1];   // each address shown twice
    assign rd.bank = rd_bank;

    // vertical blank tracking
    always_ff @(posedge clk_vga or posedge rst) begin
        if (rst) begin
            last_lvbl <= 1'b0;
            vsync_req <= 1'b0;
            vb_q      <= 1'b1;
        end else begin
            last_lvbl <= src.lvbl;
            vb_q      <= ~src.lvbl;
            if (!vsync_q)
                vsync_req <= 1'b0;          // served
            else if (last_lvbl && !src.lvbl)
                vsync_req <= 1'b1;
        end
    end

    always_ff @(posedge clk_vga or posedge rst) begin
        if (rst) begin
            state     <= SYNC;
            cnt       <= 7'(`SCAN_HSYNC_CYC - 1);
            pos       <= '0;
            act       <= 1'b0;
            right     <= 1'b0;
            wait_fall <= 1'b1;
            rd_bank   <= 1'b0;
            scanline  <= 1'b0;
            hsync_q   <= 1'b1;
            vsync_q   <= 1'b1;
            vsync_cnt <= 1'b1;
        end else begin
            case (state)
                SYNC: begin
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                    if ((wait_fall && lhbl_fall) || (!wait_fall && cnt == '0)) begin
                        state     <= FRONT;
                        cnt       <= 7'(`SCAN_FRONT_CYC - 1);
                        hsync_q   <= 1'b1;
                        wait_fall <= ~wait_fall;
                        scanline  <= ~wait_fall;    // second line of the pair
                        if (wait_fall)
                            rd_bank <= ~wr_bank;    // bank just completed
                    end
                end
                FRONT: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state <= LINE;
                        cnt   <= 7'(`SCAN_LEFT_CYC - 1);
                    end
                end
                LINE: begin
                    if (act) begin
                        pos <= pos + 1'b1;          // wraps back to zero
                        if (pos == POS_LAST) begin
                            act   <= 1'b0;
                            right <= 1'b1;
                            cnt   <= 7'(`SCAN_LEFT_CYC - 1);  // same margin as left
                        end
                    end else if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (right) begin
                        right <= 1'b0;
                        state <= BACK;
                        cnt   <= 7'(`SCAN_BACK_CYC - 1);
                    end else begin
                        act <= 1'b1;                // left margin done
                    end
                end
                BACK: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == '0) begin
                        state     <= SYNC;
                        cnt       <= 7'(`SCAN_HSYNC_CYC - 1);
                        hsync_q   <= 1'b0;
                        vsync_q   <= vsync_cnt & ~vsync_req;    // low for two lines
                        vsync_cnt <= ~vsync_req;
                    end
                end
            endcase
        end
    end

    // match buffer, expander and mixer stages
    always_ff @(posedge clk_vga or posedge rst) begin
        if (rst) begin
            de_dly <= '0;
            hb_dly <= '1;
        end else begin
            de_dly <= {de_dly[1:0], act};
            hb_dly <= {hb_dly[1:0], state != LINE};
        end
    end

    assign sync.hsync = hsync_q;
    assign sync.vsync = vsync_q;
    assign sync.hb    = hb_dly[2];
    assign sync.vb    = vb_q;
    assign sync.de    = de_dly[2];

endmodule

// File: scan_pixel_expand.sv
module scan_pixel_expand import scan_video_pkg::*; (
    input  logic    clk_vga,
    input  rgb444_t q0,
    input  rgb444_t q1,
    output rgb555_t e0,
    output rgb555_t e1
);

    // MSB copied into the new LSB so full scale stays full scale
    function automatic rgb555_t widen(input rgb444_t p);
        rgb555_t w;
        w.red   = {p.red,   p.red[3]};
        w.green = {p.green, p.green[3]};
        w.blue  = {p.blue,  p.blue[3]};
        return w;
    endfunction

    always_ff @(posedge clk_vga) begin
        e0 <= widen(q0);                // bank 0
        e1 <= widen(q1);                // bank 1
    end

endmodule

// File: scan_line_mixer.sv
module scan_line_mixer import scan_video_pkg::*; (
    input  logic    clk_vga,
    input  logic    rst,
    input  rgb555_t e0,
    input  rgb555_t e1,
    input  logic    rd_bank,
    input  logic    scanline,
    input  logic    en_mix,
    input  logic    de,
    output rgb555_t rgb
);

    rgb555_t sel;
    rgb555_t mix;
    rgb555_t pix_q;

    // floor of the mean, sum kept one bit wider
    function automatic logic [4:0] avg(input logic [4:0] a, input logic [4:0] b);
        logic [5:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[5:1];
    endfunction

    always_comb begin
        sel       = rd_bank ? e1 : e0;      // plain line
        mix.red   = avg(e0.red,   e1.red);
        mix.green = avg(e0.green, e1.green);
        mix.blue  = avg(e0.blue,  e1.blue);
    end

    always_ff @(posedge clk_vga or posedge rst) begin
        if (rst)
            pix_q <= '0;
        else
            pix_q <= (scanline && en_mix) ? mix : sel;
    end

    assign rgb = de ? pix_q : '0;           // black outside the picture

endmodule

// File: scan_doubler_top.sv
module scan_doubler_top import scan_video_pkg::*, scan_ctrl_pkg::*; (
    input  logic      clk_vga,
    input  logic      rst,
    input  rgb444_t   pix,
    input  logic      pix_cen,
    input  src_sync_t src,
    input  logic      en_mix,
    output rgb555_t   rgb,
    output vga_sync_t sync
);

    lbuf_rd_t rd;
    rgb444_t  q0;
    rgb444_t  q1;
    rgb555_t  e0;
    rgb555_t  e1;
    logic     wr_bank;
    logic     lhbl_fall;
    logic     scanline;

    scan_line_buffer #(
        .pixel_t   (rgb444_t)
    ) u_buf (
        .clk_vga   (clk_vga),
        .rst       (rst),
        .pix       (pix),
        .pix_cen   (pix_cen),
        .src       (src),
        .rd        (rd),
        .q0        (q0),
        .q1        (q1),
        .wr_bank   (wr_bank),
        .lhbl_fall (lhbl_fall)
    );

    scan_vga_timer u_timer (
        .clk_vga   (clk_vga),
        .rst       (rst),
        .src       (src),
        .lhbl_fall (lhbl_fall),
        .wr_bank   (wr_bank),
        .rd        (rd),
        .scanline  (scanline),
        .sync      (sync)
    );

    scan_pixel_expand u_expand (
        .clk_vga   (clk_vga),
        .q0        (q0),
        .q1        (q1),
        .e0        (e0),
        .e1        (e1)
    );

    scan_line_mixer u_mixer (
        .clk_vga   (clk_vga),
        .rst       (rst),
        .e0        (e0),
        .e1        (e1),
        .rd_bank   (rd.bank),
        .scanline  (scanline),
        .en_mix    (en_mix),
        .de        (sync.de),
        .rgb       (rgb)
    );

endmodule

// File: tb_scan_doubler_asserts.sv
`include "scan_cfg.svh"

module tb_scan_doubler_asserts import scan_video_pkg::*; (
    input logic      clk_vga,
    input logic      rst,
    input vga_sync_t sync
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] low_cnt;                    // length of the current hsync pulse

    always_ff @(posedge clk_vga or posedge rst) begin
        if (rst)
            low_cnt <= '0;
        else if (!sync.hsync)
            low_cnt <= low_cnt + 8'd1;
        else
            low_cnt <= '0;
    end

    hsync_width: assert property (@(posedge clk_vga) disable iff (rst)
        $rose(sync.hsync) |-> low_cnt == 8'(`SCAN_HSYNC_CYC))
        else $error("hsync pulse was %0d cycles long", low_cnt);

    // de starts one left margin after hb drops
    de_after_margin: assert property (@(posedge clk_vga) disable iff (rst)
        $rose(sync.de) |-> !sync.hb && !$past(sync.hb, `SCAN_LEFT_CYC)
                           && $past(sync.hb, `SCAN_LEFT_CYC + 1))
        else $error("de rose during horizontal blank or off the left margin");

    idle_after_reset: assert property (@(posedge clk_vga)
        $fell(rst) |-> sync.hsync && sync.vsync && sync.hb && sync.vb && !sync.de)
        else $error("timing outputs active right after reset");

endmodule

bind scan_vga_timer tb_scan_doubler_asserts u_asserts (
    .clk_vga (clk_vga),
    .rst     (rst),
    .sync    (sync)
);

// File: tb_scan_doubler.sv
`include "scan_cfg.svh"

module tb_scan_doubler import scan_video_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SRC_LINE   = 1600;       // two output lines of 800
    localparam int ACT_CYC    = 1024;       // pix_cen every fourth cycle
    localparam int FRAME_LINES = 8;
    localparam int N_FRAMES   = 3;
    localparam int N_LINES    = FRAME_LINES * N_FRAMES;
    localparam int VS_LOW     = 2 * 800;    // two output lines
    localparam int RUN_LIMIT  = (N_LINES + 2) * SRC_LINE + 2000;

    logic      clk_vga;
    logic      rst;
    rgb444_t   pix;
    logic      pix_cen;
    src_sync_t src;
    logic      en_mix;
    rgb555_t   rgb;
    vga_sync_t sync;

    integer  seed;
    int      cyc;
    int      mism;
    int      fails;
    rgb444_t bank_val [2][`SCAN_LINE_PIXELS];
    rgb444_t bank_old [2][`SCAN_LINE_PIXELS];   // content before the last write
    int      wedge    [2][`SCAN_LINE_PIXELS];   // edge of the last write
    logic    wbank;
    logic    shown_bank;
    logic    pair_first;
    logic    second;
    logic    fell_seen;
    logic    run_ok;
    logic    lhbl_d;
    logic    hs_d;
    logic    vs_d;
    logic    lvbl_d;
    int      de_run;
    int      lines_checked;
    int      hs_falls;
    int      vs_low;
    int      vs_pulses;
    rgb555_t exp_pix;

    scan_doubler_top dut0 (
        .clk_vga (clk_vga),
        .rst     (rst),
        .pix     (pix),
        .pix_cen (pix_cen),
        .src     (src),
        .en_mix  (en_mix),
        .rgb     (rgb),
        .sync    (sync)
    );

    initial begin
        clk_vga = 1'b0;
        forever #5 clk_vga = ~clk_vga;
    end

    always @(posedge clk_vga) cyc <= cyc + 1;

    always @(posedge clk_vga) begin
        if (cyc >= RUN_LIMIT) begin
            $display("timeout: no end of test after %0d cycles", RUN_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // expected output pixel from the source rules
    function automatic rgb555_t ref_pixel(input rgb444_t cur, input rgb444_t oth,
                                          input logic scan2, input logic mix);
        rgb555_t a;
        rgb555_t b;
        rgb555_t r;
        a = '{red: {cur.red, cur.red[3]}, green: {cur.green, cur.green[3]},
              blue: {cur.blue, cur.blue[3]}};
        b = '{red: {oth.red, oth.red[3]}, green: {oth.green, oth.green[3]},
              blue: {oth.blue, oth.blue[3]}};
        if (!(scan2 && mix))
            return a;
        r.red   = 5'((6'(a.red) + 6'(b.red)) >> 1);
        r.green = 5'((6'(a.green) + 6'(b.green)) >> 1);
        r.blue  = 5'((6'(a.blue) + 6'(b.blue)) >> 1);
        return r;
    endfunction

    // bank word as the buffer read it at a given edge
    function automatic rgb444_t seen_at(input logic b, input int a, input int rd_edge);
        if (wedge[b][a] < rd_edge)
            return bank_val[b][a];
        return bank_old[b][a];
    endfunction

    task automatic drive_line(input logic in_vblank);
        int i;
        int a;
        rgb444_t p;
        a = 0;
        for (i = 0; i < SRC_LINE; i++) begin
            @(posedge clk_vga);
            #1;
            src.lhbl = (i < ACT_CYC);
            src.lvbl = ~in_vblank;
            pix_cen  = 1'b0;
            if (i == ACT_CYC) begin
                shown_bank = wbank;             // line just filled is shown next
                wbank      = ~wbank;
                pair_first = 1'b1;
            end
            if (i < ACT_CYC && i % 4 == 3) begin
                p = rgb444_t'(12'($random(seed)));
                pix     = p;
                pix_cen = 1'b1;
                bank_old[wbank][a] = bank_val[wbank][a];
                bank_val[wbank][a] = p;
                wedge[wbank][a]    = cyc + 1;   // written at the coming edge
                a++;
            end
        end
    endtask

    // compare at the falling edge, well away from the drive time
    always @(negedge clk_vga) begin
        if (rst) begin
            run_ok = 1'b0;
        end else begin
            if (run_ok) begin
                assert (sync.vb == ~lvbl_d) else begin
                    mism++;
                    $display("MISMATCH %0t: vb %b for lvbl %b", $time, sync.vb, lvbl_d);
                end
            end
            run_ok = 1'b1;
            if (!fell_seen) begin
                assert (sync.hsync && sync.vsync && !sync.de) else begin
                    fails++;
                    $display("outputs became active before the first source line ended");
                end
            end
            if (lhbl_d && !src.lhbl) begin
                if (fell_seen) begin
                    assert (hs_falls == 2) else begin
                        mism++;
                        $display("MISMATCH %0t: %0d hsync pulses per source line",
                                 $time, hs_falls);
                    end
                end
                hs_falls  = 0;
                fell_seen = 1'b1;
            end
            if (hs_d && !sync.hsync)
                hs_falls++;
            if (!sync.vsync)
                vs_low++;
            if (!vs_d && sync.vsync) begin
                assert (vs_low == VS_LOW) else begin
                    mism++;
                    $display("MISMATCH %0t: vsync low %0d cycles", $time, vs_low);
                end
                vs_pulses++;
                vs_low = 0;
            end
            if (!sync.de) begin
                assert (rgb == '0) else begin
                    mism++;
                    $display("MISMATCH %0t: colour %h outside de", $time, rgb);
                end
                if (de_run != 0) begin
                    assert (de_run == 2 * `SCAN_LINE_PIXELS) else begin
                        mism++;
                        $display("MISMATCH %0t: de high %0d cycles", $time, de_run);
                    end
                    lines_checked++;
                    de_run = 0;
                end
            end else begin
                if (de_run == 0) begin
                    second     = ~pair_first;
                    pair_first = 1'b0;
                end
                exp_pix = ref_pixel(seen_at(shown_bank, de_run / 2, cyc - 2),
                                    seen_at(~shown_bank, de_run / 2, cyc - 2),
                                    second, en_mix);
                assert (rgb == exp_pix) else begin
                    mism++;
                    $display("MISMATCH %0t: pixel %0d got %h expected %h",
                             $time, de_run, rgb, exp_pix);
                end
                de_run++;
            end
        end
        lhbl_d = src.lhbl;
        lvbl_d = src.lvbl;
        hs_d   = sync.hsync;
        vs_d   = sync.vsync;
    end

    initial begin
        int f;
        int j;
        int k;
        rst     = 1'b1;
        pix     = '0;
        pix_cen = 1'b0;
        src     = '{lhbl: 1'b0, lvbl: 1'b1};
        en_mix  = 1'b0;
        seed    = 32'h2755dbad;
        cyc = 0;
        mism = 0;
        fails = 0;
        wbank = 1'b0;
        shown_bank = 1'b0;
        pair_first = 1'b0;
        second = 1'b0;
        fell_seen = 1'b0;
        run_ok = 1'b0;
        lhbl_d = 1'b0;
        lvbl_d = 1'b1;
        hs_d = 1'b1;
        vs_d = 1'b1;
        de_run = 0;
        lines_checked = 0;
        hs_falls = 0;
        vs_low = 0;
        vs_pulses = 0;
        for (k = 0; k < `SCAN_LINE_PIXELS; k++) begin
            bank_val[0][k] = '0;
            bank_val[1][k] = '0;
            bank_old[0][k] = '0;
            bank_old[1][k] = '0;
            wedge[0][k]    = -1;
            wedge[1][k]    = -1;
        end
        repeat (2) @(posedge clk_vga);
        #1 rst = 1'b0;
        for (f = 0; f < N_FRAMES; f++) begin
            en_mix = (f > 0);                   // first frame plain, then mixed
            for (j = 0; j < FRAME_LINES; j++)
                drive_line(j >= FRAME_LINES - 2);
        end
        wait (lines_checked == 2 * N_LINES);
        assert (vs_pulses == N_FRAMES) else begin
            fails++;
            $display("saw %0d vsync pulses instead of %0d", vs_pulses, N_FRAMES);
        end
        $display("errors: %0d mismatches, %0d other failures", mism, fails);
        if (mism + fails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
scan_video_pkg.sv
scan_ctrl_pkg.sv
scan_line_buffer.sv
scan_vga_timer.sv
scan_pixel_expand.sv
scan_line_mixer.sv
scan_doubler_top.sv
tb_scan_doubler_asserts.sv
tb_scan_doubler.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_scan_doubler \
    -f verilog.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
